// File: common/vectorPkg.sv
// #########################################################
// Shared types for the vector execute slice
// Register count is fixed here because instruction address
// fields are sized from it; lane count and width are parameters
// #########################################################
package vectorPkg;

	localparam int NUM_VREGS = 8;
	localparam int VREG_ADDR_W = $clog2(NUM_VREGS);

	// Lane opcode, broadcast to every lane ALU
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SLL = 3'd5,
		OP_SRL = 3'd6,
		OP_SLT = 3'd7
	} aluOpT;

	// NZCV nibble, one per lane
	typedef struct packed {
		logic n; // Result top bit
		logic z; // Result is zero
		logic c; // Carry out, ADD and SUB only
		logic v; // Signed overflow, ADD and SUB only
	} laneFlagsT;

	// Register to register instruction, 12 bits
	typedef struct packed {
		aluOpT                  op;
		logic [VREG_ADDR_W-1:0] rd;
		logic [VREG_ADDR_W-1:0] rs1;
		logic [VREG_ADDR_W-1:0] rs2;
	} vecInstrT;

endpackage

// File: vectorAlu/alu.sv
// #########################################################
// Single lane ALU, purely combinational
// Shift amount is the low log2(LANE_WIDTH) bits of B
// c and v are forced to zero outside ADD and SUB
// #########################################################
module alu import vectorPkg::*; #(
	parameter int LANE_WIDTH = 32
) (
	input  logic [LANE_WIDTH-1:0] A,
	input  logic [LANE_WIDTH-1:0] B,
	input  aluOpT                 ALUControl,
	output logic [LANE_WIDTH-1:0] result,
	output laneFlagsT             flags
);
	localparam int SHAMT_W = $clog2(LANE_WIDTH);

	logic                  subtract;
	logic                  arith;
	logic [LANE_WIDTH-1:0] addB;
	logic [LANE_WIDTH:0]   sumFull;
	logic [LANE_WIDTH-1:0] sum;
	logic                  carry;
	logic                  overflow;
	logic                  lessThan;

	// SUB and SLT share the adder as A + ~B + 1
	assign subtract = (ALUControl == OP_SUB) || (ALUControl == OP_SLT);
	assign arith = (ALUControl == OP_ADD) || (ALUControl == OP_SUB);
	assign addB = subtract ? ~B : B;

	assign sumFull = {1'b0, A} + {1'b0, addB} + {{LANE_WIDTH{1'b0}}, subtract};
	assign sum = sumFull[LANE_WIDTH-1:0];
	assign carry = sumFull[LANE_WIDTH]; // No borrow on SUB

	// Operands of equal sign giving a sum of the other sign
	assign overflow = (A[LANE_WIDTH-1] == addB[LANE_WIDTH-1]) &&
		(sum[LANE_WIDTH-1] != A[LANE_WIDTH-1]);
	assign lessThan = sum[LANE_WIDTH-1] ^ overflow; // Signed compare

	always_comb begin
		case (ALUControl)
			OP_ADD:  result = sum;
			OP_SUB:  result = sum;
			OP_AND:  result = A & B;
			OP_OR:   result = A | B;
			OP_XOR:  result = A ^ B;
			OP_SLL:  result = A << B[SHAMT_W-1:0];
			OP_SRL:  result = A >> B[SHAMT_W-1:0];
			OP_SLT:  result = {{(LANE_WIDTH-1){1'b0}}, lessThan};
			default: result = '0;
		endcase
	end

	assign flags.n = result[LANE_WIDTH-1];
	assign flags.z = ~|result;
	assign flags.c = arith & carry;
	assign flags.v = arith & overflow;

endmodule

// File: vectorAlu/aluVector.sv
// #########################################################
// Lane replicated vector ALU
// Lane 0 sits in the least significant bits of every bus
// #########################################################
module aluVector import vectorPkg::*; #(
	parameter int LANES = 8,
	parameter int LANE_WIDTH = 32,
	localparam int VEC_W = LANES * LANE_WIDTH
) (
	input  logic [VEC_W-1:0]  A,
	input  logic [VEC_W-1:0]  B,
	input  aluOpT             ALUControl,
	output logic [VEC_W-1:0]  result,
	output laneFlagsT [LANES-1:0] flags
);

	genvar lane;

	// One scalar ALU per lane, same opcode everywhere
	generate
		for (lane = 0; lane < LANES; lane++) begin : gLane
			alu #(
				.LANE_WIDTH(LANE_WIDTH)
			) laneAlu (
				.A(A[lane*LANE_WIDTH +: LANE_WIDTH]),
				.B(B[lane*LANE_WIDTH +: LANE_WIDTH]),
				.ALUControl(ALUControl),
				.result(result[lane*LANE_WIDTH +: LANE_WIDTH]),
				.flags(flags[lane])
			);
		end
	endgenerate

endmodule

// File: source/vectorRegFile.sv
// #########################################################
// Vector register file, two async reads and one clocked write
// No read bypass here; a write shows up after the clock edge
// #########################################################
module vectorRegFile import vectorPkg::*; #(
	parameter int LANES = 8,
	parameter int LANE_WIDTH = 32,
	localparam int VEC_W = LANES * LANE_WIDTH
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [VREG_ADDR_W-1:0] readAddrA,
	input  logic [VREG_ADDR_W-1:0] readAddrB,
	output logic [VEC_W-1:0]       readDataA,
	output logic [VEC_W-1:0]       readDataB,
	input  logic                   writeEn,
	input  logic [VREG_ADDR_W-1:0] writeAddr,
	input  logic [VEC_W-1:0]       writeData
);

	logic [VEC_W-1:0] regs [NUM_VREGS];

	// Every register reads zero out of reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_VREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

// File: source/vectorPipeCtrl.sv
// #########################################################
// Issue control, one instruction per cycle, no stalls
// Result appears the cycle after the edge following issue
// Writeback wins the write port; a load at that edge is lost
// #########################################################
module vectorPipeCtrl import vectorPkg::*; #(
	parameter int LANES = 8,
	parameter int LANE_WIDTH = 32,
	localparam int VEC_W = LANES * LANE_WIDTH
) (
	input  logic                   clk,
	input  logic                   rstN,

	input  logic                   instrValid,
	input  vecInstrT               instr,
	input  logic                   loadValid,
	input  logic [VREG_ADDR_W-1:0] loadAddr,
	input  logic [VEC_W-1:0]       loadData,

	output logic [VREG_ADDR_W-1:0] readAddrA,
	output logic [VREG_ADDR_W-1:0] readAddrB,
	input  logic [VEC_W-1:0]       readDataA,
	input  logic [VEC_W-1:0]       readDataB,

	output logic [VEC_W-1:0]       aluA,
	output logic [VEC_W-1:0]       aluB,
	output aluOpT                  aluOp,
	input  logic [VEC_W-1:0]       aluResult,
	input  laneFlagsT [LANES-1:0]  aluFlags,

	output logic                   writeEn,
	output logic [VREG_ADDR_W-1:0] writeAddr,
	output logic [VEC_W-1:0]       writeData,

	output logic                   resultValid,
	output logic [VREG_ADDR_W-1:0] resultAddr,
	output logic [VEC_W-1:0]       result,
	output laneFlagsT [LANES-1:0]  flags
);

	typedef struct packed {
		aluOpT                  op;
		logic [VREG_ADDR_W-1:0] rd;
		logic [VEC_W-1:0]       a;
		logic [VEC_W-1:0]       b;
	} opStageT;

	logic    opValid;
	opStageT opStage;
	logic    fwdA;
	logic    fwdB;

	assign readAddrA = instr.rs1;
	assign readAddrB = instr.rs2;

	// The register file still holds the old rd value at this edge
	assign fwdA = opValid && (instr.rs1 == opStage.rd);
	assign fwdB = opValid && (instr.rs2 == opStage.rd);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			opValid <= 1'b0;
			resultValid <= 1'b0;
		end else begin
			opValid <= instrValid;
			resultValid <= opValid;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			opStage.op <= instr.op;
			opStage.rd <= instr.rd;
			opStage.a <= fwdA ? aluResult : readDataA;
			opStage.b <= fwdB ? aluResult : readDataB;
		end
	end

	assign aluA = opStage.a;
	assign aluB = opStage.b;
	assign aluOp = opStage.op;

	// Shared write port
	assign writeEn = opValid | loadValid;
	assign writeAddr = opValid ? opStage.rd : loadAddr;
	assign writeData = opValid ? aluResult : loadData;

	// Output registers, updated together with the writeback
	always_ff @(posedge clk) begin
		if (opValid) begin
			result <= aluResult;
			flags <= aluFlags;
			resultAddr <= opStage.rd;
		end
	end

endmodule

// File: source/vectorUnit.sv
// #########################################################
// Vector execute slice top level
// Inputs are single cycle strobes, there is no back pressure
// #########################################################
module vectorUnit import vectorPkg::*; #(
	parameter int LANES = 8,
	parameter int LANE_WIDTH = 32,
	localparam int VEC_W = LANES * LANE_WIDTH
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  vecInstrT               instr,
	input  logic                   loadValid,
	input  logic [VREG_ADDR_W-1:0] loadAddr,
	input  logic [VEC_W-1:0]       loadData,
	output logic                   resultValid,
	output logic [VREG_ADDR_W-1:0] resultAddr,
	output logic [VEC_W-1:0]       result,
	output laneFlagsT [LANES-1:0]  flags
);

	logic [VREG_ADDR_W-1:0] readAddrA;
	logic [VREG_ADDR_W-1:0] readAddrB;
	logic [VEC_W-1:0]       readDataA;
	logic [VEC_W-1:0]       readDataB;
	logic [VEC_W-1:0]       aluA;
	logic [VEC_W-1:0]       aluB;
	aluOpT                  aluOp;
	logic [VEC_W-1:0]       aluResult;
	laneFlagsT [LANES-1:0]  aluFlags;
	logic                   writeEn;
	logic [VREG_ADDR_W-1:0] writeAddr;
	logic [VEC_W-1:0]       writeData;

	vectorRegFile #(
		.LANES(LANES),
		.LANE_WIDTH(LANE_WIDTH)
	) regFile (
		.clk(clk),
		.rstN(rstN),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData)
	);

	vectorPipeCtrl #(
		.LANES(LANES),
		.LANE_WIDTH(LANE_WIDTH)
	) pipeCtrl (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.loadValid(loadValid),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.aluA(aluA),
		.aluB(aluB),
		.aluOp(aluOp),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.resultValid(resultValid),
		.resultAddr(resultAddr),
		.result(result),
		.flags(flags)
	);

	aluVector #(
		.LANES(LANES),
		.LANE_WIDTH(LANE_WIDTH)
	) vecAlu (
		.A(aluA),
		.B(aluB),
		.ALUControl(aluOp),
		.result(aluResult),
		.flags(aluFlags)
	);

endmodule

// File: bench/vectorUnit_assertions.sv
// #########################################################
// Issue and writeback protocol checks bound into vectorPipeCtrl
// Reads the control block's internal operand stage valid
// #########################################################
module vectorUnit_assertions (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic loadValid,
	input logic opValid,
	input logic resultValid
);
	timeunit 1ns;
	timeprecision 1ps;

	// Quiet in reset and on the first edge after it
	resetQuietA: assert property (@(posedge clk) (!rstN || $rose(rstN)) |-> !resultValid)
		else $error("resultValid high in or right after reset");

	// Issue edge plus one edge through the operand stage
	issueToResultA: assert property (@(posedge clk) disable iff (!rstN)
		resultValid == $past(instrValid, 2))
		else $error("resultValid is not high exactly in the cycle after issue");

	// Writeback owns the write port at this edge
	noLoadCollisionA: assert property (@(posedge clk) disable iff (!rstN)
		!(loadValid && opValid))
		else $error("load coincides with a writeback and is lost");

endmodule

bind vectorPipeCtrl vectorUnit_assertions protocolChecks (
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.loadValid(loadValid),
	.opValid(opValid),
	.resultValid(resultValid)
);

// File: bench/vectorUnitTb.sv
// #########################################################
// Testbench for the vector execute slice with fixed seed 32'h44e
// Loads never share an edge with a writeback; an idle cycle goes first
// Expected values come from a lane model fed by a shadow register set
// #########################################################
module vectorUnitTb import vectorPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LANES = 8;
	localparam int LANE_WIDTH = 32;
	localparam int VEC_W = LANES * LANE_WIDTH;
	localparam int SHAMT_W = $clog2(LANE_WIDTH);
	localparam int MSB = LANE_WIDTH - 1;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_ARITH = 32;
	localparam int NUM_LOGIC = 32;
	localparam int NUM_FWD = 24;
	localparam int NUM_MIX = 200;
	// An operand case costs up to four cycles
	localparam int TEST_CYCLES = RESET_CYCLES + 2 * NUM_VREGS +
		4 * (NUM_ARITH + NUM_LOGIC) + NUM_FWD + NUM_MIX + 8;

	typedef struct packed {
		logic [31:0]            due; // Cycle count at the sampling negedge
		logic [VREG_ADDR_W-1:0] rd;
		logic [VEC_W-1:0]       res;
		laneFlagsT [LANES-1:0]  fl;
	} expEntryT;

	logic                   clk;
	logic                   rstN;
	logic                   instrValid;
	vecInstrT               instr;
	logic                   loadValid;
	logic [VREG_ADDR_W-1:0] loadAddr;
	logic [VEC_W-1:0]       loadData;
	logic                   resultValid;
	logic [VREG_ADDR_W-1:0] resultAddr;
	logic [VEC_W-1:0]       result;
	laneFlagsT [LANES-1:0]  flags;

	integer           seed = 32'h44e;
	logic [31:0]      cyc = '0;
	logic             lastIssued = 1'b0; // Writeback due at the next edge
	logic [VEC_W-1:0] shadow [NUM_VREGS];
	expEntryT         expQ [$];
	expEntryT         head;

	vectorUnit #(
		.LANES(LANES),
		.LANE_WIDTH(LANE_WIDTH)
	) UUT (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.loadValid(loadValid),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.resultValid(resultValid),
		.resultAddr(resultAddr),
		.result(result),
		.flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	initial begin
		#(TEST_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD);
		abortRun("watchdog expired before the test sequence completed");
	end

	task automatic checkResult(input logic [VEC_W-1:0] got, input logic [VEC_W-1:0] want);
		if (got !== want) abortRun($sformatf("mismatch result: got %h expected %h", got, want));
	endtask

	task automatic checkFlags(input laneFlagsT [LANES-1:0] got,
			input laneFlagsT [LANES-1:0] want);
		if (got !== want) abortRun($sformatf("mismatch flags: got %h expected %h", got, want));
	endtask

	task automatic checkAddr(input logic [VREG_ADDR_W-1:0] got,
			input logic [VREG_ADDR_W-1:0] want);
		if (got !== want) begin
			abortRun($sformatf("mismatch resultAddr: got %h expected %h", got, want));
		end
	endtask

	// Lane model where c means no borrow on SUB
	task automatic laneModel(input aluOpT op, input logic [LANE_WIDTH-1:0] a,
			input logic [LANE_WIDTH-1:0] b, output logic [LANE_WIDTH-1:0] res,
			output laneFlagsT fl);
		logic [LANE_WIDTH:0] wide;
		fl = '0;
		res = '0;
		case (op)
			OP_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[MSB:0];
				fl.c = wide[LANE_WIDTH];
				fl.v = (a[MSB] == b[MSB]) && (res[MSB] != a[MSB]);
			end
			OP_SUB: begin
				res = a - b;
				fl.c = (a >= b);
				fl.v = (a[MSB] != b[MSB]) && (res[MSB] != a[MSB]);
			end
			OP_AND: res = a & b;
			OP_OR:  res = a | b;
			OP_XOR: res = a ^ b;
			OP_SLL: res = a << b[SHAMT_W-1:0];
			OP_SRL: res = a >> b[SHAMT_W-1:0];
			default: res[0] = $signed(a) < $signed(b); // SLT
		endcase
		fl.n = res[MSB];
		fl.z = (res == '0);
	endtask

	task automatic vectorModel(input aluOpT op, input logic [VEC_W-1:0] a,
			input logic [VEC_W-1:0] b, output logic [VEC_W-1:0] res,
			output laneFlagsT [LANES-1:0] fl);
		logic [LANE_WIDTH-1:0] laneRes;
		laneFlagsT             laneFl;
		for (int i = 0; i < LANES; i++) begin
			laneModel(op, a[i*LANE_WIDTH +: LANE_WIDTH], b[i*LANE_WIDTH +: LANE_WIDTH],
				laneRes, laneFl);
			res[i*LANE_WIDTH +: LANE_WIDTH] = laneRes;
			fl[i] = laneFl;
		end
	endtask

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	function automatic logic [VEC_W-1:0] randomVector();
		logic [VEC_W-1:0] v;
		for (int i = 0; i < LANES; i++) v[i*LANE_WIDTH +: LANE_WIDTH] = randWord();
		return v;
	endfunction

	// Mostly signed and unsigned limits with some random lanes
	function automatic logic [VEC_W-1:0] cornerVector();
		logic [VEC_W-1:0] v;
		logic [31:0]      pick;
		for (int i = 0; i < LANES; i++) begin
			pick = randWord();
			case (pick[2:0])
				3'd0: v[i*LANE_WIDTH +: LANE_WIDTH] = 32'h0000_0000;
				3'd1: v[i*LANE_WIDTH +: LANE_WIDTH] = 32'h0000_0001;
				3'd2: v[i*LANE_WIDTH +: LANE_WIDTH] = 32'h7fff_ffff;
				3'd3: v[i*LANE_WIDTH +: LANE_WIDTH] = 32'h8000_0000;
				3'd4: v[i*LANE_WIDTH +: LANE_WIDTH] = 32'hffff_ffff;
				default: v[i*LANE_WIDTH +: LANE_WIDTH] = randWord();
			endcase
		end
		return v;
	endfunction

	function automatic vecInstrT randomInstr(input aluOpT op);
		vecInstrT    ins;
		logic [31:0] w;
		w = randWord();
		ins.op = op;
		ins.rd = w[0 +: VREG_ADDR_W];
		ins.rs1 = w[8 +: VREG_ADDR_W];
		ins.rs2 = w[16 +: VREG_ADDR_W];
		return ins;
	endfunction

	// One clock of stimulus that the DUT samples at the following edge
	task automatic stepCycle(input logic iv, input vecInstrT ins, input logic lv,
			input logic [VREG_ADDR_W-1:0] la, input logic [VEC_W-1:0] ld);
		logic [VEC_W-1:0]      expRes;
		laneFlagsT [LANES-1:0] expFl;
		expEntryT              entry;
		@(posedge clk);
		instrValid <= iv;
		instr <= ins;
		loadValid <= lv;
		loadAddr <= la;
		loadData <= ld;
		if (iv) vectorModel(ins.op, shadow[ins.rs1], shadow[ins.rs2], expRes, expFl);
		if (lv) shadow[la] = ld; // Operands above still see the old value
		if (iv) begin
			shadow[ins.rd] = expRes; // Writeback lands after any load of this edge
			entry.due = cyc + 3;
			entry.rd = ins.rd;
			entry.res = expRes;
			entry.fl = expFl;
			expQ.push_back(entry);
		end
		lastIssued = iv;
	endtask

	task automatic idleCycle();
		stepCycle(1'b0, '0, 1'b0, '0, '0);
	endtask

	task automatic issueInstr(input vecInstrT ins);
		stepCycle(1'b1, ins, 1'b0, '0, '0);
	endtask

	task automatic loadRegister(input logic [VREG_ADDR_W-1:0] addr,
			input logic [VEC_W-1:0] data);
		if (lastIssued) idleCycle();
		stepCycle(1'b0, '0, 1'b1, addr, data);
	endtask

	task automatic runOperandCase(input aluOpT op);
		vecInstrT ins;
		ins = randomInstr(op);
		loadRegister(ins.rs1, cornerVector());
		loadRegister(ins.rs2, cornerVector());
		issueInstr(ins);
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (resultValid) begin
			if (expQ.size() == 0) begin
				abortRun("resultValid went high with no instruction outstanding");
			end else begin
				head = expQ.pop_front();
				if (head.due != cyc) abortRun("resultValid arrived in the wrong cycle");
				checkAddr(resultAddr, head.rd);
				checkResult(result, head.res);
				checkFlags(flags, head.fl);
			end
		end else if (expQ.size() != 0 && expQ[0].due <= cyc) begin
			abortRun("resultValid did not arrive on time for an issued instruction");
		end
	end

	initial begin
		vecInstrT               ins;
		logic [31:0]            w;
		logic [2:0]             code;
		logic [VREG_ADDR_W-1:0] prevRd;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		loadValid = 1'b0;
		loadAddr = '0;
		loadData = '0;
		prevRd = '0;
		for (int r = 0; r < NUM_VREGS; r++) shadow[r] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		if (resultValid) abortRun("resultValid is high after reset release");

		// Register 0 holds zero so OR with it reads a register back
		for (int r = 0; r < NUM_VREGS; r++) begin
			loadRegister(VREG_ADDR_W'(r), (r == 0) ? '0 : randomVector());
		end
		for (int r = 0; r < NUM_VREGS; r++) begin
			ins.op = OP_OR;
			ins.rd = VREG_ADDR_W'(r);
			ins.rs1 = VREG_ADDR_W'(r);
			ins.rs2 = '0;
			issueInstr(ins);
		end

		for (int i = 0; i < NUM_ARITH; i++) begin
			w = randWord();
			if (w[0]) runOperandCase(OP_SUB);
			else runOperandCase(OP_ADD);
		end

		for (int i = 0; i < NUM_LOGIC; i++) begin
			w = randWord();
			code = 3'(w % 6) + 3'd2; // AND through SLT
			runOperandCase(aluOpT'(code));
		end

		// Each source picks up the rd of the instruction just before
		for (int i = 0; i < NUM_FWD; i++) begin
			w = randWord();
			ins = randomInstr(aluOpT'(w[10:8]));
			if (w[0]) ins.rs1 = prevRd;
			else ins.rs2 = prevRd;
			issueInstr(ins);
			prevRd = ins.rd;
		end

		for (int i = 0; i < NUM_MIX; i++) begin
			w = randWord();
			ins = randomInstr(aluOpT'(w[10:8]));
			case (w[1:0])
				2'd0: idleCycle();
				2'd1: stepCycle(1'b0, ins, !lastIssued, ins.rd, randomVector());
				2'd2: issueInstr(ins);
				default: stepCycle(1'b1, ins, !lastIssued, w[16 +: VREG_ADDR_W], cornerVector());
			endcase
		end

		repeat (4) idleCycle();
		@(negedge clk);
		if (expQ.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abortRun("results still outstanding at the end of the test");
		end
	end

endmodule

// File: list.f
common/vectorPkg.sv
vectorAlu/alu.sv
vectorAlu/aluVector.sv
source/vectorRegFile.sv
source/vectorPipeCtrl.sv
source/vectorUnit.sv
bench/vectorUnit_assertions.sv
bench/vectorUnitTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= vectorUnitTb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(BINARY)

clean:
	rm -rf $(OBJDIR)
